// ==== Bender.yml ====
package:
  name: pipeline

sources:
  - pipe_pkg.sv
  - fetch_stage.sv
  - fetch_buffer.sv
  - dispatch_stage.sv
  - execute_stage.sv
  - retire_stage.sv
  - pipeline.sv
  - target: test
    files:
      - tb_pipeline.sv

// ==== dispatch_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Dispatch stage
// Decode, xor-immediate limit, halt stop, dispatch/execute register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
	input  logic                      clock,
	input  logic                      reset,
	input  pipe_pkg::fetch_packet_t   held,
	output pipe_pkg::count_t          dispatch_count,
	output pipe_pkg::decoded_packet_t dispatched
);
	import pipe_pkg::*;

	decoded_packet_t decoded;
	// Set once a halt has left this stage
	logic            halted;
	logic            stop;
	logic            xor_seen;
	logic            halt_sent;

	always_comb begin
		dispatch_count = '0;
		stop           = halted;
		xor_seen       = 1'b0;
		halt_sent      = 1'b0;

		for (int i = 0; i < ways; i++) begin
			// Field split of the instruction word
			decoded[i].valid  = 1'b0;
			decoded[i].pc     = held[i].pc;
			decoded[i].opcode = held[i].inst.opcode;
			decoded[i].dest   = held[i].inst.dest;
			decoded[i].src    = held[i].inst.src;
			decoded[i].imm    = word_t'(held[i].inst.imm);

			if (stop || !held[i].valid) begin
				stop = 1'b1;
			end else if (held[i].inst.opcode == op_xori && xor_seen) begin
				// Single logic unit, second xori waits
				stop = 1'b1;
			end else begin
				decoded[i].valid = 1'b1;
				dispatch_count   = dispatch_count + 1'b1;
				if (held[i].inst.opcode == op_xori) begin
					xor_seen = 1'b1;
				end
				// Nothing goes out behind a halt
				if (held[i].inst.opcode == op_halt) begin
					stop      = 1'b1;
					halt_sent = 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Dispatch/execute register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		dispatched <= decoded;
		if (reset) begin
			halted <= 1'b0;
			for (int i = 0; i < ways; i++) begin
				dispatched[i].valid <= 1'b0;
			end
		end else begin
			halted <= halted | halt_sent;
		end
	end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Execute stage
// Register file, add and xor units, execute/retire register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                      clock,
	input  logic                      reset,
	input  pipe_pkg::decoded_packet_t dispatched,
	output pipe_pkg::retire_packet_t  executed
);
	import pipe_pkg::*;

	// Register 0 is never written, so it keeps its reset zero
	word_t              regs [n_regs];
	word_t [ways-1:0]   operand;
	word_t [ways-1:0]   result;
	logic  [ways-1:0]   writes;
	logic  [ways-1:0]   is_xori;
	retire_packet_t     next_executed;

	always_comb begin
		for (int i = 0; i < ways; i++) begin
			operand[i] = regs[dispatched[i].src];
			// Older ways in the same packet win over the file
			for (int j = 0; j < i; j++) begin
				if (writes[j] && dispatched[j].dest == dispatched[i].src) begin
					operand[i] = result[j];
				end
			end

			case (dispatched[i].opcode)
				op_addi: result[i] = operand[i] + dispatched[i].imm;
				op_xori: result[i] = operand[i] ^ dispatched[i].imm;
				// Halt and no-op carry zero
				default: result[i] = '0;
			endcase

			is_xori[i] = dispatched[i].valid && dispatched[i].opcode == op_xori;
			writes[i]  = dispatched[i].valid && dispatched[i].dest != '0
				&& (dispatched[i].opcode == op_addi || dispatched[i].opcode == op_xori);

			next_executed[i].valid  = dispatched[i].valid;
			next_executed[i].pc     = dispatched[i].pc;
			next_executed[i].opcode = dispatched[i].opcode;
			next_executed[i].dest   = dispatched[i].dest;
			next_executed[i].value  = result[i];
		end
	end

	////////////////////////////////////////////////////////////////////
	// Register file write and execute/retire register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		executed <= next_executed;
		if (reset) begin
			for (int r = 0; r < n_regs; r++) begin
				regs[r] <= '0;
			end
			for (int i = 0; i < ways; i++) begin
				executed[i].valid <= 1'b0;
			end
		end else begin
			// Later way last, so it wins on a shared destination
			for (int i = 0; i < ways; i++) begin
				if (writes[i]) begin
					regs[dispatched[i].dest] <= result[i];
				end
			end
		end
	end

	// Dispatch must keep the single logic unit free of conflicts
	one_xori_per_packet: assert property (
		@(posedge clock) disable iff (reset) $onehot0(is_xori)
	) else $error("more than one xori in packet, mask %b", is_xori);

endmodule

`default_nettype wire

// ==== fetch_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch/dispatch register
// Leftover entries shift to the front, new fetched entries fill in behind
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
	input  logic                    clock,
	input  logic                    reset,
	input  pipe_pkg::fetch_packet_t fetched,
	input  pipe_pkg::count_t        dispatch_count,
	output pipe_pkg::fetch_packet_t held
);
	import pipe_pkg::*;

	count_t        held_count;
	count_t        leftover;
	fetch_packet_t next_held;

	always_comb begin
		// Valid entries always sit at the front
		held_count = '0;
		for (int i = 0; i < ways; i++) begin
			if (held[i].valid) begin
				held_count = held_count + 1'b1;
			end
		end

		// Entries still waiting after this cycle's dispatch
		leftover = held_count - dispatch_count;

		for (int i = 0; i < ways; i++) begin
			if (i < leftover) begin
				next_held[i] = held[i + dispatch_count];
			end else begin
				// Oldest fetched word goes right behind the leftovers
				next_held[i] = fetched[i - leftover];
			end
		end
	end

	always_ff @(posedge clock) begin
		held <= next_held;
		if (reset) begin
			for (int i = 0; i < ways; i++) begin
				held[i].valid <= 1'b0;
			end
		end
	end

	// Dispatch only takes what the buffer holds
	count_within_held: assert property (
		@(posedge clock) disable iff (reset) dispatch_count <= held_count
	) else $error("dispatch count %0d above held count %0d", dispatch_count, held_count);

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch stage: program counter and instruction memory addressing
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  logic                                     clock,
	input  logic                                     reset,
	input  pipe_pkg::count_t                         dispatch_count,
	input  pipe_pkg::inst_t [pipe_pkg::ways-1:0]     imem_data,
	output pipe_pkg::word_t [pipe_pkg::ways-1:0]     imem_addr,
	output pipe_pkg::fetch_packet_t                  fetched
);
	import pipe_pkg::*;

	word_t  pc;
	// Low until the empty buffer has taken its first full packet
	logic   primed;
	count_t step;

	// One packet of consecutive words starting at pc
	always_comb begin
		for (int i = 0; i < ways; i++) begin
			imem_addr[i]     = pc + word_t'(4 * i);
			fetched[i].valid = 1'b1;
			fetched[i].pc    = pc + word_t'(4 * i);
			fetched[i].inst  = imem_data[i];
		end
	end

	// First packet after reset fills the whole buffer
	assign step = primed ? dispatch_count : count_t'(ways);

	always_ff @(posedge clock) begin
		if (reset) begin
			pc     <= '0;
			primed <= 1'b0;
		end else begin
			pc     <= pc + (word_t'(step) << 2);
			primed <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
pipe_pkg.sv
fetch_stage.sv
fetch_buffer.sv
dispatch_stage.sv
execute_stage.sv
retire_stage.sv
pipeline.sv
tb_pipeline.sv

// ==== pipe_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths, opcodes and stage-to-stage packets
// for the two-way in-order pipeline
//////////////////////////////////////////////////////////////////////

`default_nettype none

package pipe_pkg;

	// Machine shape
	localparam int ways   = 2;
	localparam int xlen   = 32;
	localparam int n_regs = 16;

	typedef logic [$clog2(n_regs)-1:0] reg_idx_t;
	typedef logic [xlen-1:0]           word_t;

	// Number of instructions, 0 up to ways
	typedef logic [$clog2(ways+1)-1:0] count_t;

	typedef enum logic [3:0] {
		op_nop  = 4'h0,
		op_addi = 4'h1,
		op_xori = 4'h2,
		op_halt = 4'h3
	} opcode_t;

	// Instruction word, imm is zero extended at decode
	typedef struct packed {
		opcode_t     opcode;
		reg_idx_t    dest;
		reg_idx_t    src;
		logic [3:0]  unused;
		logic [15:0] imm;
	} inst_t;

	// Fetch to dispatch
	typedef struct packed {
		logic  valid;
		word_t pc;
		inst_t inst;
	} fetch_entry_t;

	typedef fetch_entry_t [ways-1:0] fetch_packet_t;

	// Dispatch to execute
	typedef struct packed {
		logic     valid;
		word_t    pc;
		opcode_t  opcode;
		reg_idx_t dest;
		reg_idx_t src;
		word_t    imm;
	} decoded_t;

	typedef decoded_t [ways-1:0] decoded_packet_t;

	// Execute to retire
	typedef struct packed {
		logic     valid;
		word_t    pc;
		opcode_t  opcode;
		reg_idx_t dest;
		word_t    value;
	} retire_entry_t;

	typedef retire_entry_t [ways-1:0] retire_packet_t;

endpackage

`default_nettype wire

// ==== pipeline.sv ====
//////////////////////////////////////////////////////////////////////
// Two-way in-order pipeline top level
// Fetch, fetch buffer, dispatch, execute and retire
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pipeline (
	input  logic                                 clock,
	input  logic                                 reset,
	input  pipe_pkg::inst_t [pipe_pkg::ways-1:0] imem_data,
	output pipe_pkg::word_t [pipe_pkg::ways-1:0] imem_addr,
	output pipe_pkg::retire_packet_t             retire,
	output pipe_pkg::count_t                     inst_count,
	output logic                                 halt
);
	import pipe_pkg::*;

	fetch_packet_t   fetched;
	fetch_packet_t   held;
	// Level from dispatch, how many held entries left this cycle
	count_t          dispatch_count;
	decoded_packet_t dispatched;
	retire_packet_t  executed;

	////////////////////////////////////////////////////////////////////
	// Front end
	////////////////////////////////////////////////////////////////////

	fetch_stage u_fetch (
		.clock          (clock),
		.reset          (reset),
		.dispatch_count (dispatch_count),
		.imem_data      (imem_data),
		.imem_addr      (imem_addr),
		.fetched        (fetched)
	);

	fetch_buffer u_buffer (
		.clock          (clock),
		.reset          (reset),
		.fetched        (fetched),
		.dispatch_count (dispatch_count),
		.held           (held)
	);

	dispatch_stage u_dispatch (
		.clock          (clock),
		.reset          (reset),
		.held           (held),
		.dispatch_count (dispatch_count),
		.dispatched     (dispatched)
	);

	////////////////////////////////////////////////////////////////////
	// Back end
	////////////////////////////////////////////////////////////////////

	execute_stage u_execute (
		.clock      (clock),
		.reset      (reset),
		.dispatched (dispatched),
		.executed   (executed)
	);

	retire_stage u_retire (
		.clock      (clock),
		.reset      (reset),
		.executed   (executed),
		.retire     (retire),
		.inst_count (inst_count),
		.halt       (halt)
	);

endmodule

`default_nettype wire

// ==== retire_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Retire stage: retire outputs, sticky halt, retired count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module retire_stage (
	input  logic                     clock,
	input  logic                     reset,
	input  pipe_pkg::retire_packet_t executed,
	output pipe_pkg::retire_packet_t retire,
	output pipe_pkg::count_t         inst_count,
	output logic                     halt
);
	import pipe_pkg::*;

	logic halt_q;
	logic halt_now;
	// Valid entry seen behind a halt
	logic late_valid;

	always_comb begin
		inst_count = '0;
		halt_now   = 1'b0;
		late_valid = 1'b0;
		for (int i = 0; i < ways; i++) begin
			if (executed[i].valid) begin
				inst_count = inst_count + 1'b1;
				if (halt_q || halt_now) begin
					late_valid = 1'b1;
				end
				if (executed[i].opcode == op_halt) begin
					halt_now = 1'b1;
				end
			end
		end
	end

	assign retire = executed;
	// High from the halt's own retire cycle on
	assign halt   = halt_q | halt_now;

	always_ff @(posedge clock) begin
		if (reset) begin
			halt_q <= 1'b0;
		end else if (halt_now) begin
			halt_q <= 1'b1;
		end
	end

	nothing_after_halt: assert property (
		@(posedge clock) disable iff (reset) !late_valid
	) else $error("valid retire entry after halt");

endmodule

`default_nettype wire

// ==== tb_pipeline.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the two-way pipeline
// Random programs, combinational instruction memory, ISA model,
// per-cycle retire checks and a cycle limit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_pipeline;
	import pipe_pkg::*;

	localparam int max_len     = 64;
	localparam int n_programs  = 4;
	localparam int cycle_limit = n_programs * (max_len + 20);

	logic                    clock = 1'b0;
	logic                    reset;
	inst_t   [ways-1:0]      imem_data;
	word_t   [ways-1:0]      imem_addr;
	retire_packet_t          retire;
	count_t                  inst_count;
	logic                    halt;

	// Program image and the model's expected retire stream
	inst_t    prog     [max_len];
	int       prog_len = 0;
	word_t    exp_pc   [max_len];
	opcode_t  exp_op   [max_len];
	reg_idx_t exp_dest [max_len];
	word_t    exp_val  [max_len];
	int       exp_n;
	int       next_idx;
	logic     halt_seen;
	int       value_errors = 0;
	int       other_errors = 0;
	int       cycles = 0;

	pipeline u_pipeline (
		.clock      (clock),
		.reset      (reset),
		.imem_data  (imem_data),
		.imem_addr  (imem_addr),
		.retire     (retire),
		.inst_count (inst_count),
		.halt       (halt)
	);

	always #50 clock = ~clock;

	// Word-addressed memory, no-op past the end of the program
	for (genvar g = 0; g < ways; g++) begin : g_imem
		assign imem_data[g] = (imem_addr[g][xlen-1:2] < prog_len)
			? prog[imem_addr[g][xlen-1:2]] : inst_t'('0);
	end

	////////////////////////////////////////////////////////////////////
	// Program generation and ISA model
	////////////////////////////////////////////////////////////////////

	task automatic make_program(input bit force_xori);
		int      n_body;
		opcode_t op;
		word_t   model_regs [n_regs];
		word_t   val;
		n_body = 8 + int'($urandom % (max_len - 8));
		for (int k = 0; k < n_body; k++) begin
			case ($urandom % 3)
				0:       op = op_addi;
				1:       op = op_xori;
				default: op = op_nop;
			endcase
			// Mostly xori, so many packets hold two of them
			if (force_xori && ($urandom % 4) != 0) begin
				op = op_xori;
			end
			prog[k]        = '0;
			prog[k].opcode = op;
			// Few registers, so way 1 often reads way 0's result
			prog[k].dest   = reg_idx_t'($urandom % 8);
			prog[k].src    = reg_idx_t'($urandom % 8);
			prog[k].imm    = 16'($urandom);
		end
		prog[n_body]        = '0;
		prog[n_body].opcode = op_halt;
		prog_len            = n_body + 1;

		// Reset clears the register file
		for (int r = 0; r < n_regs; r++) begin
			model_regs[r] = '0;
		end
		for (int k = 0; k < prog_len; k++) begin
			case (prog[k].opcode)
				op_addi: val = model_regs[prog[k].src] + word_t'(prog[k].imm);
				op_xori: val = model_regs[prog[k].src] ^ word_t'(prog[k].imm);
				default: val = '0;
			endcase
			if ((prog[k].opcode == op_addi || prog[k].opcode == op_xori)
				&& prog[k].dest != 0) begin
				model_regs[prog[k].dest] = val;
			end
			exp_pc[k]   = word_t'(4 * k);
			exp_op[k]   = prog[k].opcode;
			exp_dest[k] = prog[k].dest;
			exp_val[k]  = val;
		end
		exp_n = prog_len;
	endtask

	////////////////////////////////////////////////////////////////////
	// Retire checks, one call per cycle
	////////////////////////////////////////////////////////////////////

	task automatic check_retire();
		int   n_valid;
		int   n_xori;
		logic halt_here;
		n_valid   = 0;
		n_xori    = 0;
		halt_here = 1'b0;
		for (int i = 0; i < ways; i++) begin
			if (retire[i].valid) begin
				n_valid++;
				if (retire[i].opcode == op_xori) begin
					n_xori++;
				end
				assert (!halt_seen && !halt_here) else begin
					other_errors++;
					$display("valid retire entry after halt at time %0t", $time);
				end
				if (next_idx < exp_n) begin
					assert (retire[i].pc == exp_pc[next_idx]
						&& retire[i].opcode == exp_op[next_idx]
						&& retire[i].dest == exp_dest[next_idx]) else begin
						value_errors++;
						$display("Fail %0t: way %0d pc/op/rd %h/%0d/%0d, expected %h/%0d/%0d",
							$time, i, retire[i].pc, retire[i].opcode, retire[i].dest,
							exp_pc[next_idx], exp_op[next_idx], exp_dest[next_idx]);
					end
					assert (retire[i].value == exp_val[next_idx]) else begin
						value_errors++;
						$display("Fail %0t: pc %h value %h, expected %h",
							$time, retire[i].pc, retire[i].value, exp_val[next_idx]);
					end
				end else begin
					other_errors++;
					$display("more instructions retired than the program holds");
				end
				if (retire[i].opcode == op_halt) begin
					halt_here = 1'b1;
				end
				next_idx++;
			end
		end
		assert (inst_count == n_valid) else begin
			value_errors++;
			$display("Fail %0t: inst_count %0d, expected %0d", $time, inst_count, n_valid);
		end
		// Single logic unit
		assert (n_xori <= 1) else begin
			value_errors++;
			$display("Fail %0t: %0d xori retired in one cycle", $time, n_xori);
		end
		assert (halt == (halt_seen || halt_here)) else begin
			value_errors++;
			$display("Fail %0t: halt %b, expected %b", $time, halt, halt_seen || halt_here);
		end
		halt_seen = halt_seen || halt_here;
	endtask

	task automatic run_program(input bit force_xori);
		@(posedge clock);
		reset <= 1'b1;
		@(negedge clock);
		make_program(force_xori);
		repeat (10) @(posedge clock);
		reset     <= 1'b0;
		next_idx  = 0;
		halt_seen = 1'b0;
		// First cycle out of reset is quiet
		@(negedge clock);
		assert (!halt && inst_count == 0 && !retire[0].valid && !retire[1].valid) else begin
			other_errors++;
			$display("halt or retire entry active right after reset");
		end
		while (!halt_seen) begin
			@(negedge clock);
			check_retire();
		end
		// Drain, nothing may follow the halt
		repeat (3) begin
			@(negedge clock);
			check_retire();
		end
		assert (next_idx == exp_n) else begin
			other_errors++;
			$display("retired %0d of %0d instructions", next_idx, exp_n);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, halt never retired", cycles);
			$display("errors: %0d value, %0d other", value_errors, other_errors);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		reset <= 1'b1;
		void'($urandom(70));
		for (int p = 0; p < n_programs; p++) begin
			run_program(p == 0);
		end
		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
